//--- all.f
hdl/sv32Pkg.sv
hdl/walkerPkg.sv
hdl/walkRequestQueue.sv
hdl/pageWalker.sv
hdl/leafCheck.sv
hdl/pageTableMemory.sv
hdl/pageWalkTop.sv
verification/pageWalk_props.sv
verification/pageWalkTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the page walker testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module pageWalkTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VpageWalkTb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0

//--- verification/pageWalkTb.sv
`timescale 1ns/1ns

module pageWalkTb
    import sv32Pkg::*;
    import walkerPkg::*;
();

    localparam int ClkPeriod = 40;
    localparam int ResetCycles = 10;
    localparam int NumCases = 12;
    // single walks with and without stalls, plus three triples
    localparam int NumWalks = 2 * NumCases + 9;
    // two levels with random stalls fit easily
    localparam int WalkBound = 60;
    localparam int SetupBound = ResetCycles + 40;
    localparam int RunCycles = 4 * (SetupBound + NumWalks * WalkBound);
    localparam int ExpDepth = 16;
    localparam ppnT RootPpn = 22'd1;
    localparam ppnT LeafTablePpn = 22'd2;

    localparam logic [7:0] FlagV = 8'(1 << PteV);
    localparam logic [7:0] FlagR = 8'(1 << PteR);
    localparam logic [7:0] FlagW = 8'(1 << PteW);
    localparam logic [7:0] FlagX = 8'(1 << PteX);
    localparam logic [7:0] FlagU = 8'(1 << PteU);
    localparam logic [7:0] FlagG = 8'(1 << PteG);
    localparam logic [7:0] FlagA = 8'(1 << PteA);
    localparam logic [7:0] FlagD = 8'(1 << PteD);

    typedef struct packed {
        rqIdT id;
        vpnT  vpn;
        ppnT  ppn;
        logic superPage;
        logic fault;
        rwxT  rwx;
        logic isGlobal;
        logic isUser;
    } resultT;

    logic clk;
    logic rst;
    logic [NumRqs-1:0] rqValid;
    vaddrT rqVaddr [NumRqs];
    ppnT rqRootPpn [NumRqs];
    logic memStall = 1'b0;
    logic memWrite;
    memIdxT memWriteIdx;
    pteT memWriteData;
    logic busy;
    logic resValid;
    rqIdT resRqId;
    vpnT resVpn;
    ppnT resPpn;
    logic resSuperPage;
    logic resPageFault;
    rwxT resRwx;
    logic resGlobal;
    logic resUser;

    // copy of everything written into the page-table memory
    pteT tbl [MemWords];
    resultT expTab [ExpDepth];
    string expName [ExpDepth];
    int expHead = 0;
    int expTail = 0;
    int errors = 0;
    logic stallOn = 1'b0;
    vaddrT caseVa [NumCases];
    string caseName [NumCases];

    pageWalkTop DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        memStall = stallOn && (($urandom % 3) == 0);
    end

    function automatic pteT makePte(ppnT ppn, logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic vaddrT makeVa(int vpn1, int vpn0);
        return {10'(vpn1), 10'(vpn0), 12'h5a4};
    endfunction

    function automatic memIdxT tableIdx(ppnT tablePpn, int field);
        return memIdxT'(int'(tablePpn) * (1 << VpnFieldBits) + field);
    endfunction

    // walks the table copy by the Sv32 rules
    function automatic resultT predict(rqIdT id, vaddrT va, ppnT root);
        resultT r;
        paddrT addr;
        pteT pte;
        logic [2:0] xwr;
        logic bad;
        addr = {root[19:0], va[31:22], 2'b00};
        pte = tbl[addr[13:2]];
        r.superPage = 1'b1;
        // only a bare V entry with a reachable target leads on to level 0
        if (pte[3:0] == 4'b0001 && pte[31:30] == 2'b00) begin
            addr = {pte[29:10], va[21:12], 2'b00};
            if (addr < paddrT'(MemWords * PteBytes)) begin
                pte = tbl[addr[13:2]];
                r.superPage = 1'b0;
            end
        end
        xwr = pte[3:1];
        bad = !pte[PteV] || !pte[PteA];
        bad = bad || xwr == 3'b000 || xwr == 3'b010 || xwr == 3'b110;
        bad = bad || (r.superPage && pte[19:10] != 10'd0);
        r.id = id;
        r.vpn = va[31:12];
        r.ppn = pte[31:10];
        r.fault = bad;
        r.rwx = bad ? 3'b000 : {pte[PteR], pte[PteW] && pte[PteD], pte[PteX]};
        r.isGlobal = !bad && pte[PteG];
        r.isUser = !bad && pte[PteU];
        return r;
    endfunction

    task automatic checkField(string name, string field, int expected, int actual);
        assert (expected == actual) else begin
            errors++;
            $display("Fail %s %s expected 0x%0h actual 0x%0h", name, field, expected, actual);
        end
    endtask

    always @(negedge clk) begin
        resultT e;
        string n;
        // the walker only works while a request is outstanding
        if (busy) begin
            assert (expHead != expTail) else begin
                errors++;
                $display("walker busy with no request outstanding");
            end
        end
        if (resValid) begin
            assert (expHead != expTail) else begin
                errors++;
                $display("result from requester %0d arrived with no walk outstanding", resRqId);
            end
            if (expHead != expTail) begin
                e = expTab[expHead % ExpDepth];
                n = expName[expHead % ExpDepth];
                expHead++;
                checkField(n, "rqId", int'(e.id), int'(resRqId));
                checkField(n, "vpn", int'(e.vpn), int'(resVpn));
                checkField(n, "ppn", int'(e.ppn), int'(resPpn));
                checkField(n, "superPage", int'(e.superPage), int'(resSuperPage));
                checkField(n, "pageFault", int'(e.fault), int'(resPageFault));
                checkField(n, "rwx", int'(e.rwx), int'(resRwx));
                checkField(n, "global", int'(e.isGlobal), int'(resGlobal));
                checkField(n, "user", int'(e.isUser), int'(resUser));
            end
        end
    end

    task automatic setPte(memIdxT idx, pteT value);
        @(negedge clk);
        memWrite = 1'b1;
        memWriteIdx = idx;
        memWriteData = value;
        tbl[idx] = value;
        @(negedge clk);
        memWrite = 1'b0;
    endtask

    task automatic addCase(int i, string name, int vpn1, int vpn0);
        caseName[i] = name;
        caseVa[i] = makeVa(vpn1, vpn0);
    endtask

    task automatic buildTables();
        setPte(tableIdx(RootPpn, 'h005), makePte(22'h000c00, FlagV | FlagR | FlagX | FlagA | FlagG));
        setPte(tableIdx(RootPpn, 'h006),
            makePte(22'h001400, FlagV | FlagR | FlagW | FlagA | FlagD | FlagU));
        setPte(tableIdx(RootPpn, 'h007), makePte(22'h000400, FlagV | FlagR | FlagW | FlagA));
        setPte(tableIdx(RootPpn, 'h010), makePte(LeafTablePpn, FlagV));
        setPte(tableIdx(RootPpn, 'h020), makePte(22'h000000, FlagR | FlagX | FlagA));
        setPte(tableIdx(RootPpn, 'h021), makePte(22'h000800, FlagV | FlagR));
        setPte(tableIdx(RootPpn, 'h022), makePte(22'h000000, FlagV | FlagW | FlagA));
        setPte(tableIdx(RootPpn, 'h023), makePte(22'h000000, FlagV | FlagW | FlagX | FlagA));
        setPte(tableIdx(RootPpn, 'h024), makePte(22'h000801, FlagV | FlagR | FlagA));
        // target far above the 16 KiB memory
        setPte(tableIdx(RootPpn, 'h025), makePte(22'h000100, FlagV));
        setPte(tableIdx(RootPpn, 'h026), makePte(22'h200002, FlagV));
        setPte(tableIdx(LeafTablePpn, 'h045), makePte(22'h12345,
            FlagV | FlagR | FlagW | FlagX | FlagA | FlagD | FlagU | FlagG));
        setPte(tableIdx(LeafTablePpn, 'h046), makePte(22'd3, FlagV));
        addCase(0, "superpage", 'h005, 'h123);
        addCase(1, "dirtyWrite", 'h006, 'h000);
        addCase(2, "cleanWrite", 'h007, 'h3ff);
        addCase(3, "twoLevel", 'h010, 'h045);
        addCase(4, "vClear", 'h020, 'h001);
        addCase(5, "aClear", 'h021, 'h002);
        addCase(6, "reservedW", 'h022, 'h003);
        addCase(7, "reservedWX", 'h023, 'h004);
        addCase(8, "misaligned", 'h024, 'h005);
        addCase(9, "level0Pointer", 'h010, 'h046);
        addCase(10, "illegalPointer", 'h025, 'h006);
        addCase(11, "highPpnPointer", 'h026, 'h007);
    endtask

    task automatic expectResult(rqIdT id, vaddrT va, string name);
        expTab[expTail % ExpDepth] = predict(id, va, RootPpn);
        expName[expTail % ExpDepth] = name;
        expTail++;
    endtask

    task automatic drive(rqIdT id, vaddrT va);
        rqValid[id] = 1'b1;
        rqVaddr[id] = va;
        rqRootPpn[id] = RootPpn;
    endtask

    task automatic waitDrained();
        while (expHead != expTail || busy) begin
            @(negedge clk);
        end
    endtask

    task automatic runSingle(rqIdT id, vaddrT va, string name);
        expectResult(id, va, name);
        @(negedge clk);
        drive(id, va);
        @(negedge clk);
        rqValid = '0;
        waitDrained();
    endtask

    task automatic runSimultaneous(string name);
        expectResult(2'd0, caseVa[0], {name, "Rq0"});
        expectResult(2'd1, caseVa[3], {name, "Rq1"});
        expectResult(2'd2, caseVa[6], {name, "Rq2"});
        @(negedge clk);
        drive(2'd0, caseVa[0]);
        drive(2'd1, caseVa[3]);
        drive(2'd2, caseVa[6]);
        @(negedge clk);
        rqValid = '0;
        waitDrained();
    endtask

    // rq2 walks alone, rq1 then rq0 arrive behind it and rq0 goes first
    task automatic runWhileBusy();
        expectResult(2'd2, caseVa[3], "busyFirst");
        expectResult(2'd0, caseVa[5], "busyLowest");
        expectResult(2'd1, caseVa[2], "busyNext");
        @(negedge clk);
        drive(2'd2, caseVa[3]);
        @(negedge clk);
        rqValid = '0;
        while (!busy) begin
            @(negedge clk);
        end
        drive(2'd1, caseVa[2]);
        @(negedge clk);
        rqValid = '0;
        drive(2'd0, caseVa[5]);
        @(negedge clk);
        rqValid = '0;
        waitDrained();
    endtask

    initial begin
        #(RunCycles * ClkPeriod);
        $display("timeout after %0d cycles, %0d results never arrived",
            RunCycles, expTail - expHead);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(67));
        rst = 1'b1;
        rqValid = '0;
        memWrite = 1'b0;
        memWriteIdx = '0;
        memWriteData = '0;
        for (int i = 0; i < NumRqs; i++) begin
            rqVaddr[i] = '0;
            rqRootPpn[i] = '0;
        end
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        buildTables();
        for (int i = 0; i < NumCases; i++) begin
            runSingle(rqIdT'(i % NumRqs), caseVa[i], caseName[i]);
        end
        runSimultaneous("simultaneous");
        runWhileBusy();
        stallOn = 1'b1;
        for (int i = 0; i < NumCases; i++) begin
            runSingle(rqIdT'((i + 1) % NumRqs), caseVa[i], {caseName[i], "Stalled"});
        end
        runSimultaneous("simultaneousStalled");
        stallOn = 1'b0;
        repeat (4) @(negedge clk);
        $display("check errors %0d, property errors %0d, missing results %0d",
            errors, DUT.walker.props.propErrors, expTail - expHead);
        if (errors == 0 && DUT.walker.props.propErrors == 0 && expTail == expHead) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verification/pageWalk_props.sv
`timescale 1ns/1ns

module pageWalk_props
    import sv32Pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  issueValid,
    input logic  busy,
    input logic  ldValid,
    input paddrT ldAddr,
    input logic  ldStall,
    input logic  leafValid
);

    // failed property count
    int propErrors = 0;

    // a stalled load keeps its valid and its address
    loadHeld: assert property (@(posedge clk) disable iff (rst)
        ldValid && ldStall |=> ldValid && $stable(ldAddr))
    else begin
        propErrors++;
        $error("stalled load changed its address or dropped its valid");
    end

    // resValid is this strobe one cycle later
    leafPulse: assert property (@(posedge clk) disable iff (rst)
        leafValid |=> !leafValid)
    else begin
        propErrors++;
        $error("leaf strobe stayed high for two cycles");
    end

    noIssueWhileBusy: assert property (@(posedge clk) disable iff (rst)
        !(issueValid && busy))
    else begin
        propErrors++;
        $error("request issued while the walker was busy");
    end

endmodule

bind pageWalker pageWalk_props props (
    .clk(clk), .rst(rst),
    .issueValid(issueValid), .busy(busy),
    .ldValid(ldValid), .ldAddr(ldAddr), .ldStall(ldStall),
    .leafValid(leafValid)
);

//--- hdl/pageWalkTop.sv
`timescale 1ns/1ns

module pageWalkTop
    import sv32Pkg::*;
    import walkerPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [NumRqs-1:0] rqValid,
    input  vaddrT             rqVaddr [NumRqs],
    input  ppnT               rqRootPpn [NumRqs],
    input  logic              memStall,
    input  logic              memWrite,
    input  memIdxT            memWriteIdx,
    input  pteT               memWriteData,
    output logic              busy,
    output logic              resValid,
    output rqIdT              resRqId,
    output vpnT               resVpn,
    output ppnT               resPpn,
    output logic              resSuperPage,
    output logic              resPageFault,
    output rwxT               resRwx,
    output logic              resGlobal,
    output logic              resUser
);

    logic issueValid;
    rqIdT issueRqId;
    vaddrT issueVaddr;
    ppnT issueRootPpn;
    logic ldValid;
    paddrT ldAddr;
    logic ldResValid;
    pteT ldResData;
    logic leafValid;
    pteT leafPte;
    logic leafSuperPage;
    vpnT leafVpn;
    rqIdT leafRqId;

    walkRequestQueue requestQueue (
        .clk(clk), .rst(rst),
        .rqValid(rqValid), .rqVaddr(rqVaddr), .rqRootPpn(rqRootPpn),
        .busy(busy),
        .issueValid(issueValid), .issueRqId(issueRqId),
        .issueVaddr(issueVaddr), .issueRootPpn(issueRootPpn)
    );

    pageWalker walker (
        .clk(clk), .rst(rst),
        .issueValid(issueValid), .issueRqId(issueRqId),
        .issueVaddr(issueVaddr), .issueRootPpn(issueRootPpn),
        .busy(busy),
        .ldValid(ldValid), .ldAddr(ldAddr), .ldStall(memStall),
        .ldResValid(ldResValid), .ldResData(ldResData),
        .leafValid(leafValid), .leafPte(leafPte), .leafSuperPage(leafSuperPage),
        .leafVpn(leafVpn), .leafRqId(leafRqId)
    );

    leafCheck check (
        .clk(clk), .rst(rst),
        .leafValid(leafValid), .leafPte(leafPte), .leafSuperPage(leafSuperPage),
        .leafVpn(leafVpn), .leafRqId(leafRqId),
        .resValid(resValid), .resRqId(resRqId), .resVpn(resVpn), .resPpn(resPpn),
        .resSuperPage(resSuperPage), .resPageFault(resPageFault), .resRwx(resRwx),
        .resGlobal(resGlobal), .resUser(resUser)
    );

    pageTableMemory tableMem (
        .clk(clk), .rst(rst),
        .memWrite(memWrite), .memWriteIdx(memWriteIdx), .memWriteData(memWriteData),
        .ldValid(ldValid), .ldAddr(ldAddr), .ldStall(memStall),
        .ldResValid(ldResValid), .ldResData(ldResData)
    );

endmodule

//--- hdl/pageTableMemory.sv
`timescale 1ns/1ns

module pageTableMemory
    import sv32Pkg::*;
    import walkerPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   memWrite,
    input  memIdxT memWriteIdx,
    input  pteT    memWriteData,
    input  logic   ldValid,
    input  paddrT  ldAddr,
    input  logic   ldStall,
    output logic   ldResValid,
    output pteT    ldResData
);

    pteT mem [MemWords];
    memIdxT ldIdx;
    logic accept;
    logic [LoadLatency-1:0] pipeValid;
    pteT pipeData [LoadLatency];

    // word index is the byte address over the entry size
    assign ldIdx = ldAddr[$clog2(PteBytes) +: $bits(memIdxT)];
    assign accept = ldValid && !ldStall;

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[memWriteIdx] <= memWriteData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pipeValid <= '0;
        end else begin
            pipeValid <= {pipeValid[LoadLatency-2:0], accept};
        end
    end

    always_ff @(posedge clk) begin
        pipeData[0] <= mem[ldIdx];
        for (int i = 1; i < LoadLatency; i++) begin
            pipeData[i] <= pipeData[i-1];
        end
    end

    assign ldResValid = pipeValid[LoadLatency-1];
    assign ldResData = pipeData[LoadLatency-1];

endmodule

//--- hdl/leafCheck.sv
`timescale 1ns/1ns

module leafCheck
    import sv32Pkg::*;
    import walkerPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic leafValid,
    input  pteT  leafPte,
    input  logic leafSuperPage,
    input  vpnT  leafVpn,
    input  rqIdT leafRqId,
    output logic resValid,
    output rqIdT resRqId,
    output vpnT  resVpn,
    output ppnT  resPpn,
    output logic resSuperPage,
    output logic resPageFault,
    output rwxT  resRwx,
    output logic resGlobal,
    output logic resUser
);

    logic fault;
    logic [2:0] xwr;

    assign xwr = {leafPte[PteX], leafPte[PteW], leafPte[PteR]};

    always_comb begin
        fault = !leafPte[PteV] || !leafPte[PteA];
        // invalid or reserved flag codes
        if (xwr == 3'b000 || xwr == 3'b010 || xwr == 3'b110) begin
            fault = 1'b1;
        end
        // a superpage must be 4 MiB aligned
        if (leafSuperPage && leafPte[PpnLsb +: VpnFieldBits] != '0) begin
            fault = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= leafValid;
        end
    end

    always_ff @(posedge clk) begin
        if (leafValid) begin
            resRqId <= leafRqId;
            resVpn <= leafVpn;
            resPpn <= leafPte[$bits(pteT)-1:PpnLsb];
            resSuperPage <= leafSuperPage;
            resPageFault <= fault;
            // write only once the page is dirty
            resRwx <= fault ? '0 : {leafPte[PteR], leafPte[PteW] && leafPte[PteD], leafPte[PteX]};
            resGlobal <= !fault && leafPte[PteG];
            resUser <= !fault && leafPte[PteU];
        end
    end

endmodule

//--- hdl/pageWalker.sv
`timescale 1ns/1ns

module pageWalker
    import sv32Pkg::*;
    import walkerPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  issueValid,
    input  rqIdT  issueRqId,
    input  vaddrT issueVaddr,
    input  ppnT   issueRootPpn,
    output logic  busy,
    output logic  ldValid,
    output paddrT ldAddr,
    input  logic  ldStall,
    input  logic  ldResValid,
    input  pteT   ldResData,
    output logic  leafValid,
    output pteT   leafPte,
    output logic  leafSuperPage,
    output vpnT   leafVpn,
    output rqIdT  leafRqId
);

    walkStateT state;
    // 1 while the level-1 entry is being fetched
    logic levelOne;
    vaddrT curVaddr;
    rqIdT curRqId;
    paddrT rootAddr;
    paddrT nextAddr;
    logic isPointer;

    // root ppn, upper vpn field, entry offset
    assign rootAddr = {
        issueRootPpn[$bits(paddrT)-PageOffsetBits-1:0],
        issueVaddr[$bits(vaddrT)-1 -: VpnFieldBits],
        {$clog2(PteBytes){1'b0}}
    };

    // pointer ppn, lower vpn field, entry offset
    assign nextAddr = {
        ldResData[PpnLsb +: $bits(paddrT)-PageOffsetBits],
        curVaddr[PageOffsetBits +: VpnFieldBits],
        {$clog2(PteBytes){1'b0}}
    };

    // only V set among the low flags, top ppn bits clear, target inside memory
    assign isPointer = levelOne
        && ldResData[PteV] && !ldResData[PteR] && !ldResData[PteW] && !ldResData[PteX]
        && ldResData[$bits(pteT)-1 -: 2] == 2'b00
        && nextAddr < paddrT'(MemWords * PteBytes);

    assign busy = (state != IDLE);
    assign ldValid = (state == LOAD_ISSUE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            leafValid <= 1'b0;
        end else begin
            leafValid <= 1'b0;
            case (state)
                IDLE: begin
                    if (issueValid) begin
                        state <= LOAD_ISSUE;
                    end
                end
                LOAD_ISSUE: begin
                    if (!ldStall) begin
                        state <= WAIT_RESULT;
                    end
                end
                WAIT_RESULT: begin
                    if (ldResValid) begin
                        if (isPointer) begin
                            state <= LOAD_ISSUE;
                        end else begin
                            state <= IDLE;
                            leafValid <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // walk context and leaf payload
    always_ff @(posedge clk) begin
        if (state == IDLE && issueValid) begin
            curVaddr <= issueVaddr;
            curRqId <= issueRqId;
            levelOne <= 1'b1;
            ldAddr <= rootAddr;
        end
        if (state == WAIT_RESULT && ldResValid) begin
            if (isPointer) begin
                levelOne <= 1'b0;
                ldAddr <= nextAddr;
            end else begin
                leafPte <= ldResData;
                leafSuperPage <= levelOne;
                leafVpn <= curVaddr[$bits(vaddrT)-1:PageOffsetBits];
                leafRqId <= curRqId;
            end
        end
    end

endmodule

//--- hdl/walkRequestQueue.sv
`timescale 1ns/1ns

module walkRequestQueue
    import sv32Pkg::*;
    import walkerPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [NumRqs-1:0] rqValid,
    input  vaddrT             rqVaddr [NumRqs],
    input  ppnT               rqRootPpn [NumRqs],
    input  logic              busy,
    output logic              issueValid,
    output rqIdT              issueRqId,
    output vaddrT             issueVaddr,
    output ppnT               issueRootPpn
);

    logic [NumRqs-1:0] pending;
    logic [NumRqs-1:0] accept;
    vaddrT pendVaddr [NumRqs];
    ppnT pendRootPpn [NumRqs];
    logic selFound;
    rqIdT selIdx;
    logic canIssue;

    // lowest pending index wins
    always_comb begin
        selFound = 1'b0;
        selIdx = '0;
        for (int i = NumRqs - 1; i >= 0; i--) begin
            if (pending[i]) begin
                selFound = 1'b1;
                selIdx = rqIdT'(i);
            end
        end
    end

    // busy rises one cycle after an issue, so skip the cycle right after one
    assign canIssue = selFound && !busy && !issueValid;

    // a slot takes a new strobe when empty or when it is issued this cycle
    always_comb begin
        for (int i = 0; i < NumRqs; i++) begin
            accept[i] = rqValid[i] && (!pending[i] || (canIssue && selIdx == rqIdT'(i)));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            issueValid <= 1'b0;
        end else begin
            issueValid <= canIssue;
            for (int i = 0; i < NumRqs; i++) begin
                if (accept[i]) begin
                    pending[i] <= 1'b1;
                end else if (canIssue && selIdx == rqIdT'(i)) begin
                    pending[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NumRqs; i++) begin
            if (accept[i]) begin
                pendVaddr[i] <= rqVaddr[i];
                pendRootPpn[i] <= rqRootPpn[i];
            end
        end
        if (canIssue) begin
            issueRqId <= selIdx;
            issueVaddr <= pendVaddr[selIdx];
            issueRootPpn <= pendRootPpn[selIdx];
        end
    end

endmodule

//--- hdl/walkerPkg.sv
package walkerPkg;

    // number of tlb-miss sources
    localparam int NumRqs = 3;
    typedef logic [1:0] rqIdT;

    // 16 KiB of page-table memory
    localparam int MemWords = 4096;
    typedef logic [11:0] memIdxT;

    // cycles from an accepted load to its result strobe
    localparam int LoadLatency = 2;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_ISSUE,
        WAIT_RESULT
    } walkStateT;

endpackage

//--- hdl/sv32Pkg.sv
package sv32Pkg;

    typedef logic [31:0] vaddrT;
    // physical addresses stop at 32 bits
    typedef logic [31:0] paddrT;
    typedef logic [19:0] vpnT;
    typedef logic [21:0] ppnT;
    typedef logic [31:0] pteT;
    // ordered as {r, w, x}
    typedef logic [2:0] rwxT;

    // pte flag bits
    localparam int PteV = 0;
    localparam int PteR = 1;
    localparam int PteW = 2;
    localparam int PteX = 3;
    localparam int PteU = 4;
    localparam int PteG = 5;
    localparam int PteA = 6;
    localparam int PteD = 7;

    // ppn field occupies pte[31:10]
    localparam int PpnLsb = 10;

    localparam int PteBytes = 4;
    localparam int PageOffsetBits = 12;
    // each of the two vpn fields
    localparam int VpnFieldBits = 10;

endpackage
